// File: include/soc_glue_settings.svh
/*
 * Global sizes for the SoC glue logic
 * Bus word and address widths, slot and register split,
 * GPIO port count and width, reset settle and LED hold-off counters
 */

`ifndef SOC_GLUE_SETTINGS_SVH
`define SOC_GLUE_SETTINGS_SVH

// Bus word width in bits
`define DATA_W 32

// Word address width
`define ADDR_W 8

// Upper address bits pick a slot, lower bits pick a register
`define SLOT_W 4
`define REG_W 4

// GPIO ports and pins per port
`define GPIO_COUNT 2
`define GPIO_W 16

// Settle counter reloads to all ones
`define SETTLE_W 6

// Activity LED hold-off
`define ACT_HOLD_W 7

`endif

// File: design/soc_glue_pkg.sv
/*
 * Shared types for the SoC glue logic
 * Bus op codes, slot map, device ids,
 * GPIO register offsets and software reset codes
 */

package soc_glue_pkg;

`include "soc_glue_settings.svh"

	// Plain bus op codes, a swap is handled as a read
	typedef enum logic [1:0] {
		OP_NONE  = 2'd0,
		OP_WRITE = 2'd1,
		OP_READ  = 2'd2,
		OP_RDWR  = 2'd3
	} bus_op_t;

	// Slots 2 .. 2+GPIO_COUNT-1 are GPIO ports, the rest are invalid
	typedef enum logic [`SLOT_W-1:0] {
		SLOT_RSTCTRL = `SLOT_W'd0,
		SLOT_DEVTBL  = `SLOT_W'd1,
		SLOT_GPIO0   = `SLOT_W'd2
	} slot_t;

	typedef logic [`DATA_W-1:0] dev_id_t;

	localparam dev_id_t DEVID_RSTCTRL = dev_id_t'(7);
	localparam dev_id_t DEVID_GPIO    = dev_id_t'(6);
	localparam dev_id_t DEVID_NONE    = dev_id_t'(0);

	localparam logic [`REG_W-1:0] GPIO_REG_IN  = `REG_W'd0;
	localparam logic [`REG_W-1:0] GPIO_REG_OUT = `REG_W'd1;
	localparam logic [`REG_W-1:0] GPIO_REG_IRQ = `REG_W'd2;

	// Data bits {1,0} of a reset control write
	typedef enum logic [1:0] {
		RST_NONE   = 2'b00,
		RST_PWROFF = 2'b01,
		RST_WARM   = 2'b10,
		RST_COLD   = 2'b11
	} rst_req_t;

endpackage

// File: design/reset_seq.sv
/*
 * Reset sequencer
 * Settle counter, software reset decode, power-off latch
 */

`timescale 1ns/1ps

`include "soc_glue_settings.svh"

module reset_seq import soc_glue_pkg::*; (
	input  logic       clk_2x_w,
	input  logic       rst_p,
	input  logic       rst_req_i,
	input  logic [1:0] rst_data_i,
	output logic       sys_rst_o,
	output logic       bus_rdy_o
);

	logic [`SETTLE_W-1:0] settle_cnt;
	logic                 pwroff_latch;
	logic [1:0]           swrst_pipe;
	logic [1:0]           pwroff_pipe;
	logic                 warm_req;
	logic                 cold_req;
	logic                 pwroff_req;

	always_comb begin
		warm_req = 1'b0;
		cold_req = 1'b0;
		pwroff_req = 1'b0;
		if (rst_req_i) begin
			case (rst_req_t'(rst_data_i))
				RST_WARM:   warm_req = 1'b1;
				RST_COLD:   cold_req = 1'b1;
				RST_PWROFF: pwroff_req = 1'b1;
				default:    ;
			endcase
		end
	end

	// Hold requests back until the ack of the write has gone out
	always_ff @(posedge clk_2x_w) begin
		if (rst_p) begin
			swrst_pipe <= '0;
			pwroff_pipe <= '0;
		end else begin
			swrst_pipe <= {swrst_pipe[0], warm_req | cold_req};
			pwroff_pipe <= {pwroff_pipe[0], pwroff_req};
		end
	end

	always_ff @(posedge clk_2x_w) begin
		if (rst_p || swrst_pipe[1])
			settle_cnt <= '1;
		else if (settle_cnt != '0)
			settle_cnt <= settle_cnt - 1'b1;
	end

	// Only the board reset releases power-off
	always_ff @(posedge clk_2x_w) begin
		if (rst_p)
			pwroff_latch <= 1'b0;
		else if (pwroff_pipe[1])
			pwroff_latch <= 1'b1;
	end

	assign sys_rst_o = (settle_cnt != '0) | pwroff_latch;
	assign bus_rdy_o = ~sys_rst_o;

endmodule

// File: design/bus_decode.sv
/*
 * Bus request decoder
 * Registers accepted requests, splits slot and register,
 * routes ops to GPIO ports and reset writes to the sequencer
 */

`timescale 1ns/1ps

`include "soc_glue_settings.svh"

module bus_decode import soc_glue_pkg::*; (
	input  logic                clk_2x_w,
	input  logic                sys_rst_i,
	input  logic                bus_rdy_i,
	input  bus_op_t             bus_op_i,
	input  logic [`ADDR_W-1:0]  bus_addr_i,
	input  logic [`DATA_W-1:0]  bus_data_i,
	output bus_op_t             slot_op_o [`GPIO_COUNT],
	output logic [`REG_W-1:0]   slot_reg_o,
	output logic [`DATA_W-1:0]  slot_data_o,
	output logic                rst_req_o,
	output logic [1:0]          rst_data_o,
	output slot_t               resp_slot_o,
	output logic [`REG_W-1:0]   resp_reg_o,
	output logic                resp_valid_o
);

	logic              take;
	bus_op_t           op_norm;
	slot_t             addr_slot;
	logic [`REG_W-1:0] addr_reg;

	assign take = bus_rdy_i && (bus_op_i != OP_NONE);
	// Swap behaves as a plain read
	assign op_norm = (bus_op_i == OP_RDWR) ? OP_READ : bus_op_i;
	assign addr_slot = slot_t'(bus_addr_i[`ADDR_W-1 -: `SLOT_W]);
	assign addr_reg = bus_addr_i[`REG_W-1:0];

	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i) begin
			for (int i = 0; i < `GPIO_COUNT; i++)
				slot_op_o[i] <= OP_NONE;
			rst_req_o <= 1'b0;
			resp_valid_o <= 1'b0;
		end else begin
			// Only the addressed port sees the op
			for (int i = 0; i < `GPIO_COUNT; i++) begin
				if (take && int'(addr_slot) == int'(SLOT_GPIO0) + i)
					slot_op_o[i] <= op_norm;
				else
					slot_op_o[i] <= OP_NONE;
			end
			rst_req_o <= take && (op_norm == OP_WRITE) && (addr_slot == SLOT_RSTCTRL);
			resp_valid_o <= take;
		end
	end

	always_ff @(posedge clk_2x_w) begin
		if (take) begin
			slot_reg_o <= addr_reg;
			slot_data_o <= bus_data_i;
			rst_data_o <= bus_data_i[1:0];
			resp_slot_o <= addr_slot;
			resp_reg_o <= addr_reg;
		end
	end

endmodule

// File: design/gpio_port.sv
/*
 * GPIO port
 * Two-flop input sync, output register,
 * per-pin change pending bits with write-one-to-clear
 */

`timescale 1ns/1ps

`include "soc_glue_settings.svh"

module gpio_port import soc_glue_pkg::*; (
	input  logic               clk_2x_w,
	input  logic               sys_rst_i,
	input  bus_op_t            op_i,
	input  logic [`REG_W-1:0]  reg_i,
	input  logic [`DATA_W-1:0] data_i,
	input  logic [`GPIO_W-1:0] pins_i,
	output logic [`GPIO_W-1:0] pins_o,
	output logic [`DATA_W-1:0] rdata_o,
	output logic               irq_o
);

	logic [`GPIO_W-1:0] sync_meta;
	logic [`GPIO_W-1:0] sync_pins;
	logic [`GPIO_W-1:0] prev_pins;
	logic [`GPIO_W-1:0] pending;
	logic [`GPIO_W-1:0] out_r;
	logic [`GPIO_W-1:0] irq_clr;
	logic               wr_en;

	assign wr_en = (op_i == OP_WRITE);
	assign irq_clr = (wr_en && reg_i == GPIO_REG_IRQ) ? data_i[`GPIO_W-1:0] : '0;

	// Pins are asynchronous to the bus clock
	always_ff @(posedge clk_2x_w) begin
		sync_meta <= pins_i;
		sync_pins <= sync_meta;
		prev_pins <= sync_pins;
	end

	// A new edge beats a clear in the same cycle
	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i)
			pending <= '0;
		else
			pending <= (pending & ~irq_clr) | (sync_pins ^ prev_pins);
	end

	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i)
			out_r <= '0;
		else if (wr_en && reg_i == GPIO_REG_OUT)
			out_r <= data_i[`GPIO_W-1:0];
	end

	always_ff @(posedge clk_2x_w) begin
		if (op_i == OP_READ) begin
			case (reg_i)
				GPIO_REG_IN:  rdata_o <= `DATA_W'(sync_pins);
				GPIO_REG_OUT: rdata_o <= `DATA_W'(out_r);
				GPIO_REG_IRQ: rdata_o <= `DATA_W'(pending);
				default:      rdata_o <= '0;
			endcase
		end
	end

	assign pins_o = out_r;
	assign irq_o = |pending;

endmodule

// File: design/bus_respond.sv
/*
 * Bus response stage
 * Device table lookup, invalid-slot default,
 * GPIO read word select and ack
 */

`timescale 1ns/1ps

`include "soc_glue_settings.svh"

module bus_respond import soc_glue_pkg::*; (
	input  logic               clk_2x_w,
	input  logic               sys_rst_i,
	input  slot_t              resp_slot_i,
	input  logic [`REG_W-1:0]  resp_reg_i,
	input  logic               resp_valid_i,
	input  logic [`DATA_W-1:0] gpio_rdata_i [`GPIO_COUNT],
	output logic [`DATA_W-1:0] bus_data_o,
	output logic               bus_ack_o
);

	logic                   valid_q;
	logic [`GPIO_COUNT-1:0] gpio_sel;
	logic [`GPIO_COUNT-1:0] gpio_sel_q;
	dev_id_t                local_word;
	dev_id_t                local_word_q;
	logic [`DATA_W-1:0]     resp_word;

	// Register index names a slot, device table slot itself reads as none
	function automatic dev_id_t devtbl_lookup(input logic [`REG_W-1:0] idx);
		dev_id_t id;
		id = DEVID_NONE;
		if (int'(idx) == int'(SLOT_RSTCTRL))
			id = DEVID_RSTCTRL;
		else if (int'(idx) >= int'(SLOT_GPIO0) && int'(idx) < int'(SLOT_GPIO0) + `GPIO_COUNT)
			id = DEVID_GPIO;
		return id;
	endfunction

	always_comb begin
		for (int i = 0; i < `GPIO_COUNT; i++)
			gpio_sel[i] = (int'(resp_slot_i) == int'(SLOT_GPIO0) + i);
		// Reset control and invalid slots read zero
		if (resp_slot_i == SLOT_DEVTBL)
			local_word = devtbl_lookup(resp_reg_i);
		else
			local_word = '0;
	end

	// Wait one cycle for the GPIO port read register
	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i)
			valid_q <= 1'b0;
		else
			valid_q <= resp_valid_i;
	end

	always_ff @(posedge clk_2x_w) begin
		gpio_sel_q <= gpio_sel;
		local_word_q <= local_word;
	end

	always_comb begin
		resp_word = local_word_q;
		for (int i = 0; i < `GPIO_COUNT; i++) begin
			if (gpio_sel_q[i])
				resp_word = gpio_rdata_i[i];
		end
	end

	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i)
			bus_ack_o <= 1'b0;
		else
			bus_ack_o <= valid_q;
	end

	always_ff @(posedge clk_2x_w) begin
		bus_data_o <= resp_word;
	end

endmodule

// File: design/activity_led.sv
/*
 * Activity LED
 * One-cycle pulse per event with a hold-off that dims it
 */

`timescale 1ns/1ps

`include "soc_glue_settings.svh"

module activity_led (
	input  logic clk_2x_w,
	input  logic sys_rst_i,
	input  logic event_i,
	output logic led_o
);

	logic [`ACT_HOLD_W-1:0] hold_cnt;
	logic                   fire;

	assign fire = event_i && (hold_cnt == '0);

	// Events during hold-off are dropped
	always_ff @(posedge clk_2x_w) begin
		if (sys_rst_i) begin
			hold_cnt <= '0;
			led_o <= 1'b0;
		end else begin
			led_o <= fire;
			if (fire)
				hold_cnt <= '1;
			else if (hold_cnt != '0)
				hold_cnt <= hold_cnt - 1'b1;
		end
	end

endmodule

// File: design/soc_glue_top.sv
/*
 * SoC glue top level
 * Reset sequencer, bus decoder, GPIO ports,
 * response stage and activity LED
 */

`timescale 1ns/1ps

`include "soc_glue_settings.svh"

module soc_glue_top import soc_glue_pkg::*; (
	input  logic                                 clk_2x_w,
	input  logic                                 rst_p,
	input  bus_op_t                              bus_op_i,
	input  logic [`ADDR_W-1:0]                   bus_addr_i,
	input  logic [`DATA_W-1:0]                   bus_data_i,
	output logic                                 bus_rdy_o,
	output logic [`DATA_W-1:0]                   bus_data_o,
	output logic                                 bus_ack_o,
	input  logic [`GPIO_COUNT-1:0][`GPIO_W-1:0]  gpio_i,
	output logic [`GPIO_COUNT-1:0][`GPIO_W-1:0]  gpio_o,
	output logic [`GPIO_COUNT-1:0]               gpio_irq_o,
	output logic                                 activity_led_o
);

	logic               sys_rst;
	bus_op_t            slot_op [`GPIO_COUNT];
	logic [`REG_W-1:0]  slot_reg;
	logic [`DATA_W-1:0] slot_data;
	logic               rst_req;
	logic [1:0]         rst_data;
	slot_t              resp_slot;
	logic [`REG_W-1:0]  resp_reg;
	logic               resp_valid;
	logic [`DATA_W-1:0] gpio_rdata [`GPIO_COUNT];

	reset_seq u_reset_seq (
		.clk_2x_w   (clk_2x_w),
		.rst_p      (rst_p),
		.rst_req_i  (rst_req),
		.rst_data_i (rst_data),
		.sys_rst_o  (sys_rst),
		.bus_rdy_o  (bus_rdy_o)
	);

	bus_decode u_bus_decode (
		.clk_2x_w     (clk_2x_w),
		.sys_rst_i    (sys_rst),
		.bus_rdy_i    (bus_rdy_o),
		.bus_op_i     (bus_op_i),
		.bus_addr_i   (bus_addr_i),
		.bus_data_i   (bus_data_i),
		.slot_op_o    (slot_op),
		.slot_reg_o   (slot_reg),
		.slot_data_o  (slot_data),
		.rst_req_o    (rst_req),
		.rst_data_o   (rst_data),
		.resp_slot_o  (resp_slot),
		.resp_reg_o   (resp_reg),
		.resp_valid_o (resp_valid)
	);

	// One port per GPIO slot
	for (genvar g = 0; g < `GPIO_COUNT; g++) begin : g_gpio
		gpio_port u_gpio_port (
			.clk_2x_w  (clk_2x_w),
			.sys_rst_i (sys_rst),
			.op_i      (slot_op[g]),
			.reg_i     (slot_reg),
			.data_i    (slot_data),
			.pins_i    (gpio_i[g]),
			.pins_o    (gpio_o[g]),
			.rdata_o   (gpio_rdata[g]),
			.irq_o     (gpio_irq_o[g])
		);
	end

	bus_respond u_bus_respond (
		.clk_2x_w     (clk_2x_w),
		.sys_rst_i    (sys_rst),
		.resp_slot_i  (resp_slot),
		.resp_reg_i   (resp_reg),
		.resp_valid_i (resp_valid),
		.gpio_rdata_i (gpio_rdata),
		.bus_data_o   (bus_data_o),
		.bus_ack_o    (bus_ack_o)
	);

	activity_led u_activity_led (
		.clk_2x_w  (clk_2x_w),
		.sys_rst_i (sys_rst),
		.event_i   (bus_ack_o),
		.led_o     (activity_led_o)
	);

endmodule

// File: sim/tb_soc_glue.sv
/*
 * Self-checking testbench for the SoC glue top level
 * Table of bus accesses with expected read data, GPIO change interrupts,
 * software warm reset and power-off, activity LED dimming
 */

`timescale 1ns/1ps

`include "soc_glue_settings.svh"

module tb_soc_glue import soc_glue_pkg::*; ();

	localparam int TBL_LEN = 32;
	localparam int CYCLE_LIMIT = TBL_LEN * 4 + 3 * 200;

	logic                                clk_2x_w = 1'b0;
	logic                                rst_p;
	bus_op_t                             bus_op;
	logic [`ADDR_W-1:0]                  bus_addr;
	logic [`DATA_W-1:0]                  bus_wdata;
	logic                                bus_rdy;
	logic [`DATA_W-1:0]                  bus_rdata;
	logic                                bus_ack;
	logic [`GPIO_COUNT-1:0][`GPIO_W-1:0] gpio_in;
	logic [`GPIO_COUNT-1:0][`GPIO_W-1:0] gpio_out;
	logic [`GPIO_COUNT-1:0]              gpio_irq;
	logic                                led;

	// Access table
	bus_op_t            tbl_op   [TBL_LEN];
	logic [`ADDR_W-1:0] tbl_addr [TBL_LEN];
	logic [`DATA_W-1:0] tbl_data [TBL_LEN];
	logic [`DATA_W-1:0] tbl_exp  [TBL_LEN];
	int                 entry_cnt = 0;

	logic [15:0] lfsr_state = 16'd61273;
	int          mismatch_errs = 0;
	int          other_errs = 0;
	int          cycle_cnt = 0;
	int          led_pulses = 0;

	soc_glue_top dut (
		.clk_2x_w       (clk_2x_w),
		.rst_p          (rst_p),
		.bus_op_i       (bus_op),
		.bus_addr_i     (bus_addr),
		.bus_data_i     (bus_wdata),
		.bus_rdy_o      (bus_rdy),
		.bus_data_o     (bus_rdata),
		.bus_ack_o      (bus_ack),
		.gpio_i         (gpio_in),
		.gpio_o         (gpio_out),
		.gpio_irq_o     (gpio_irq),
		.activity_led_o (led)
	);

	always #2 clk_2x_w = ~clk_2x_w;

	// LED pulses seen at each edge, old value before the update
	always @(posedge clk_2x_w) begin
		if (led === 1'b1)
			led_pulses++;
	end

	always @(posedge clk_2x_w) begin
		cycle_cnt++;
		if (cycle_cnt >= CYCLE_LIMIT) begin
			$display("run stopped after %0d cycles without finishing", cycle_cnt);
			$display("errors: %0d mismatches, %0d other failures", mismatch_errs, other_errs);
			$display("CHECKS FAILED");
			$finish;
		end
	end

	// Galois LFSR, one step per bit taken
	function automatic logic [31:0] lfsr_bits(input int n);
		logic [31:0] v;
		logic        b;
		v = '0;
		for (int i = 0; i < n; i++) begin
			b = lfsr_state[0];
			lfsr_state = {1'b0, lfsr_state[15:1]} ^ (b ? 16'hB400 : 16'h0000);
			v = {v[30:0], b};
		end
		return v;
	endfunction

	function automatic logic [`ADDR_W-1:0] addr_of(input int slot, input int regi);
		return `ADDR_W'((slot << `REG_W) | regi);
	endfunction

	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		assert (got === exp) else begin
			mismatch_errs++;
			$display("mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		assert (cond === 1'b1) else begin
			other_errs++;
			$display("at %0t: %s", $time, what);
		end
	endtask

	task automatic add_entry(input bus_op_t op, input logic [`ADDR_W-1:0] addr,
			input logic [`DATA_W-1:0] data, input logic [`DATA_W-1:0] exp);
		if (entry_cnt < TBL_LEN) begin
			tbl_op[entry_cnt] = op;
			tbl_addr[entry_cnt] = addr;
			tbl_data[entry_cnt] = data;
			tbl_exp[entry_cnt] = exp;
		end
		entry_cnt++;
	endtask

	task automatic build_table();
		logic [`DATA_W-1:0] d;
		logic [`DATA_W-1:0] id;
		for (int p = 0; p < `GPIO_COUNT; p++) begin
			for (int k = 0; k < 3; k++) begin
				d = lfsr_bits(32);
				add_entry(OP_WRITE, addr_of(int'(SLOT_GPIO0) + p, GPIO_REG_OUT), d, '0);
				add_entry(OP_READ, addr_of(int'(SLOT_GPIO0) + p, GPIO_REG_OUT), '0,
					`DATA_W'(d[`GPIO_W-1:0]));
			end
		end
		// Device table word n describes slot n
		for (int w = 0; w < 16; w++) begin
			if (w == 0)
				id = DEVID_RSTCTRL;
			else if (w >= 2 && w < 2 + `GPIO_COUNT)
				id = DEVID_GPIO;
			else
				id = DEVID_NONE;
			add_entry(OP_READ, addr_of(int'(SLOT_DEVTBL), w), '0, id);
		end
		add_entry(OP_RDWR, addr_of(int'(SLOT_DEVTBL), 0), '0, DEVID_RSTCTRL);
		add_entry(OP_READ, addr_of(5, 3), '0, '0);
		add_entry(OP_READ, addr_of(15, 15), '0, '0);
		add_entry(OP_READ, addr_of(int'(SLOT_RSTCTRL), 0), '0, '0);
	endtask

	// One request, then wait for its ack and check the latency
	task automatic bus_access(input bus_op_t op, input logic [`ADDR_W-1:0] addr,
			input logic [`DATA_W-1:0] wdata, output logic [`DATA_W-1:0] rdata);
		int   lat;
		logic got_ack;
		@(posedge clk_2x_w);
		#1;
		check_true(bus_rdy, "request offered while bus_rdy_o is low");
		bus_op = op;
		bus_addr = addr;
		bus_wdata = wdata;
		@(posedge clk_2x_w);
		#1;
		bus_op = OP_NONE;
		lat = 0;
		got_ack = 1'b0;
		while (!got_ack && lat < 8) begin
			@(negedge clk_2x_w);
			if (bus_ack === 1'b1)
				got_ack = 1'b1;
			else
				lat++;
		end
		check_true(got_ack, "no bus_ack_o for a request");
		check_value("bus_ack_o latency", lat, 2);
		rdata = bus_rdata;
	endtask

	task automatic wait_ready_level(input logic level, input int max_cycles, input bit quiet,
			input string what);
		int n;
		n = 0;
		while (bus_rdy !== level && n < max_cycles) begin
			@(negedge clk_2x_w);
			if (quiet && bus_rdy !== level)
				check_true(bus_ack == 1'b0 && gpio_out == '0 && gpio_irq == '0 && led == 1'b0,
					"an output was active while bus_rdy_o was low");
			n++;
		end
		check_true(bus_rdy === level, what);
	endtask

	initial begin
		logic [`DATA_W-1:0] rd;
		logic [`GPIO_W-1:0] old_pins;
		logic [`GPIO_W-1:0] new_pins;
		int                 p;
		int                 pulse_base;

		rst_p = 1'b1;
		bus_op = OP_NONE;
		bus_addr = '0;
		bus_wdata = '0;
		gpio_in = '0;
		build_table();

		repeat (8) @(posedge clk_2x_w);
		#1;
		rst_p = 1'b0;
		wait_ready_level(1'b1, 70, 1'b1, "bus_rdy_o did not rise after reset");

		for (int i = 0; i < TBL_LEN; i++) begin
			bus_access(tbl_op[i], tbl_addr[i], tbl_data[i], rd);
			if (tbl_op[i] == OP_WRITE) begin
				p = int'(tbl_addr[i][`ADDR_W-1 -: `SLOT_W]) - int'(SLOT_GPIO0);
				check_value($sformatf("gpio_o[%0d]", p), 32'(gpio_out[p]),
					32'(tbl_data[i][`GPIO_W-1:0]));
			end else begin
				check_value("bus_data_o", rd, tbl_exp[i]);
			end
		end

		// Pin changes raise pending bits, a write of ones clears them
		for (int g = 0; g < `GPIO_COUNT; g++) begin
			old_pins = gpio_in[g];
			new_pins = old_pins ^ `GPIO_W'(lfsr_bits(`GPIO_W));
			if (new_pins == old_pins)
				new_pins = ~old_pins;
			@(posedge clk_2x_w);
			#1;
			gpio_in[g] = new_pins;
			repeat (4) @(posedge clk_2x_w);
			bus_access(OP_READ, addr_of(int'(SLOT_GPIO0) + g, GPIO_REG_IN), '0, rd);
			check_value("bus_data_o", rd, `DATA_W'(new_pins));
			bus_access(OP_READ, addr_of(int'(SLOT_GPIO0) + g, GPIO_REG_IRQ), '0, rd);
			check_value("bus_data_o", rd, `DATA_W'(old_pins ^ new_pins));
			check_value($sformatf("gpio_irq_o[%0d]", g), 32'(gpio_irq[g]), 32'd1);
			bus_access(OP_WRITE, addr_of(int'(SLOT_GPIO0) + g, GPIO_REG_IRQ),
				`DATA_W'(old_pins ^ new_pins), rd);
			check_value($sformatf("gpio_irq_o[%0d]", g), 32'(gpio_irq[g]), 32'd0);
			bus_access(OP_READ, addr_of(int'(SLOT_GPIO0) + g, GPIO_REG_IRQ), '0, rd);
			check_value("bus_data_o", rd, '0);
		end

		// Warm reset clears the output registers
		bus_access(OP_WRITE, addr_of(int'(SLOT_RSTCTRL), 0), 32'h2, rd);
		wait_ready_level(1'b0, 8, 1'b0, "bus_rdy_o did not fall after the warm reset write");
		wait_ready_level(1'b1, 70, 1'b0, "bus_rdy_o did not rise after the warm reset");
		for (int g = 0; g < `GPIO_COUNT; g++) begin
			check_value($sformatf("gpio_o[%0d]", g), 32'(gpio_out[g]), '0);
			bus_access(OP_READ, addr_of(int'(SLOT_GPIO0) + g, GPIO_REG_OUT), '0, rd);
			check_value("bus_data_o", rd, '0);
		end

		// Power-off holds until the board reset
		bus_access(OP_WRITE, addr_of(int'(SLOT_RSTCTRL), 0), 32'h1, rd);
		wait_ready_level(1'b0, 8, 1'b0, "bus_rdy_o did not fall after the power-off write");
		repeat (200) begin
			@(negedge clk_2x_w);
			check_true(bus_rdy === 1'b0, "bus_rdy_o rose while power-off was latched");
		end
		@(posedge clk_2x_w);
		#1;
		rst_p = 1'b1;
		repeat (8) @(posedge clk_2x_w);
		#1;
		rst_p = 1'b0;
		wait_ready_level(1'b1, 70, 1'b1, "bus_rdy_o did not rise after the board reset");

		// Bus has been quiet for well over 128 cycles here
		bus_access(OP_READ, addr_of(int'(SLOT_DEVTBL), 0), '0, rd);
		check_value("activity_led_o", 32'(led), 32'd0);
		@(negedge clk_2x_w);
		check_value("activity_led_o", 32'(led), 32'd1);
		@(negedge clk_2x_w);
		check_value("activity_led_o", 32'(led), 32'd0);
		pulse_base = led_pulses;
		repeat (4) bus_access(OP_READ, addr_of(int'(SLOT_DEVTBL), 2), '0, rd);
		check_true(led_pulses == pulse_base, "activity_led_o pulsed again during hold-off");

		$display("errors: %0d mismatches, %0d other failures", mismatch_errs, other_errs);
		if (mismatch_errs == 0 && other_errs == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

endmodule

// File: list.f
+incdir+include
design/soc_glue_pkg.sv
design/reset_seq.sv
design/bus_decode.sv
design/gpio_port.sv
design/bus_respond.sv
design/activity_led.sv
design/soc_glue_top.sv
sim/tb_soc_glue.sv

// File: Bender.yml
package:
  name: soc_glue

export_include_dirs:
  - include

sources:
  - files:
      - design/soc_glue_pkg.sv
      - design/reset_seq.sv
      - design/bus_decode.sv
      - design/gpio_port.sv
      - design/bus_respond.sv
      - design/activity_led.sv
      - design/soc_glue_top.sv

  - target: simulation
    files:
      - sim/tb_soc_glue.sv
